// File: rtl/dispatch_top.sv
`timescale 1ns/100ps

module dispatch_top import pip_types_pkg::*; #(
  parameter int ROB_DEPTHLOG2 = 4,
  parameter int FETCH_DEPTH   = 4,
  parameter int IQ_DEPTH      = 4
) (
  input  logic            clock,
  input  logic            reset_n,
  input  logic            fetch_valid,
  input  fetch_bundle_t   fetch_bundle,
  output logic            fetch_ready,
  input  logic            flush,
  input  logic            flush_stream,
  input  logic            retire_valid,
  input  logic [1:0]      retire_count,
  output logic            group_valid,
  output dispatch_group_t group,
  input  logic            group_ready
);

  fetch_bundle_t                        fq_head;
  logic                                 fq_valid;
  logic                                 fq_pop;
  logic                                 fq_full;
  logic                                 reserve;
  logic [1:0]                           reserve_count;
  logic [LANES-1:0][ROB_DEPTHLOG2-1:0] reserved_slots;
  logic                                 rob_full;
  logic                                 ins_enable;
  dispatch_group_t                      new_group;
  logic                                 iq_full;

  assign fetch_ready = ~fq_full;

  entry_fifo #(
    .DEPTH     (FETCH_DEPTH),
    .payload_t (fetch_bundle_t)
  ) u_fetch_q (
    .clock     (clock),
    .reset_n   (reset_n),
    .push      (fetch_valid),  // the queue ignores a push while full
    .push_data (fetch_bundle),
    .full      (fq_full),
    .pop       (fq_pop),
    .pop_data  (fq_head),
    .pop_valid (fq_valid)
  );

  id #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2)
  ) u_id (
    .clock          (clock),
    .reset_n        (reset_n),
    .bundle         (fq_head),
    .bundle_valid   (fq_valid),
    .bundle_pop     (fq_pop),
    .flush          (flush),
    .flush_stream   (flush_stream),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full),
    .ins_enable     (ins_enable),
    .new_group      (new_group),
    .iq_full        (iq_full)
  );

  rob_alloc #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2)
  ) u_rob_alloc (
    .clock          (clock),
    .reset_n        (reset_n),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .retire_valid   (retire_valid),
    .retire_count   (retire_count),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full)
  );

  entry_fifo #(
    .DEPTH     (IQ_DEPTH),
    .payload_t (dispatch_group_t)
  ) u_issue_q (
    .clock     (clock),
    .reset_n   (reset_n),
    .push      (ins_enable),
    .push_data (new_group),
    .full      (iq_full),
    .pop       (group_ready),
    .pop_data  (group),
    .pop_valid (group_valid)
  );

endmodule

// File: rtl/entry_fifo.sv
`timescale 1ns/100ps

module entry_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     pop_valid
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          live;
  logic          do_push;
  logic          do_pop;

  // pointers wrap explicitly so DEPTH need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // the queue reports full until the first edge after reset
  assign full      = ~live | (count == CW'(DEPTH));
  assign pop_valid = (count != '0);
  assign pop_data  = mem[rd_ptr];

  assign do_push = push & ~full;
  assign do_pop  = pop & pop_valid;

  always_ff @(posedge clock) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      live   <= 1'b0;
    end else begin
      live <= 1'b1;
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

endmodule

// File: rtl/id.sv
`timescale 1ns/100ps

module id import pip_types_pkg::*; #(
  parameter int ROB_DEPTHLOG2 = 4
) (
  input  logic                                 clock,
  input  logic                                 reset_n,
  input  fetch_bundle_t                        bundle,
  input  logic                                 bundle_valid,
  output logic                                 bundle_pop,
  input  logic                                 flush,
  input  logic                                 flush_stream,
  output logic                                 reserve,
  output logic [1:0]                           reserve_count,
  input  logic [LANES-1:0][ROB_DEPTHLOG2-1:0] reserved_slots,
  input  logic                                 rob_full,
  output logic                                 ins_enable,
  output dispatch_group_t                      new_group,
  input  logic                                 iq_full
);

  dec_inst_t  dec_inst [LANES];
  logic       flush_r;
  logic       flush_stream_r;
  logic       stall;
  logic       any_valid;
  logic       drop;
  logic [2:0] lane_cnt;

  for (genvar i = 0; i < LANES; i++) begin : g_dec
    idec u_idec (
      .pc        (bundle.pc[i]),
      .inst_word (bundle.inst_word[i]),
      .di        (dec_inst[i])
    );
  end

  // ******************************
  // flush tracking
  // ******************************

  // the flushed stream stays blocked until the other stream shows up at decode
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      flush_r        <= 1'b0;
      flush_stream_r <= 1'b0;
    end else if (flush) begin
      flush_r        <= 1'b1;
      flush_stream_r <= flush_stream;
    end else if (flush_r && bundle_valid && (bundle.stream != flush_stream_r)) begin
      flush_r        <= 1'b0;
      flush_stream_r <= 1'b0;
    end
  end

  assign drop = (flush   && (bundle.stream == flush_stream))
              | (flush_r && (bundle.stream == flush_stream_r));

  // ******************************
  // stall, reserve and pop
  // ******************************

  always_comb begin
    lane_cnt = '0;
    for (int i = 0; i < LANES; i++)
      lane_cnt += 3'(bundle.lane_valid[i]);
  end

  assign any_valid     = |bundle.lane_valid;
  assign reserve_count = 2'(lane_cnt - 3'd1);  // don't care while reserve is low
  assign stall         = rob_full | iq_full;

  assign ins_enable = bundle_valid & any_valid & ~drop & ~stall;
  assign reserve    = ins_enable;

  // dropped and empty bundles leave the queue even while stalled
  assign bundle_pop = bundle_valid & (ins_enable | drop | ~any_valid);

  // ******************************
  // lane compaction
  // ******************************

  always_comb begin
    logic [1:0] slot;

    new_group          = '0;
    new_group.count_m1 = reserve_count;
    for (int k = 0; k < LANES; k++) begin
      new_group.entries[k].rob_slot = 8'(reserved_slots[k]);
      new_group.entries[k].stream   = bundle.stream;
    end

    // lowest valid lane goes first, later ones fill in behind it
    slot = '0;
    for (int i = 0; i < LANES; i++) begin
      if (bundle.lane_valid[i]) begin
        new_group.entries[slot].dec_inst = dec_inst[i];
        slot = slot + 1'b1;
      end
    end
  end

endmodule

// File: rtl/idec.sv
`timescale 1ns/100ps

module idec import pip_types_pkg::*; (
  input  logic [31:0] pc,
  input  logic [31:0] inst_word,
  output dec_inst_t   di
);

  localparam logic [6:0] OPC_ALU     = 7'b0110011;
  localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;

  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        writes_rd;

  assign opcode = inst_word[6:0];
  assign rd     = inst_word[11:7];
  assign rs1    = inst_word[19:15];
  assign rs2    = inst_word[24:20];

  // immediates for every format, sign bit is always bit 31
  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'h000};
  assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                  inst_word[20], inst_word[30:21], 1'b0};

  always_comb begin
    di         = '0;
    di.pc      = pc;
    di.op      = op_illegal;
    di.illegal = 1'b0;
    writes_rd  = 1'b0;

    case (opcode)
      OPC_ALU: begin
        di.op     = op_alu;
        di.src1   = rs1;
        di.src2   = rs2;
        writes_rd = 1'b1;
      end
      OPC_ALU_IMM: begin
        di.op     = op_alu_imm;
        di.src1   = rs1;
        di.imm    = imm_i;
        writes_rd = 1'b1;
      end
      OPC_LOAD: begin
        di.op     = op_load;
        di.src1   = rs1;
        di.imm    = imm_i;
        writes_rd = 1'b1;
      end
      OPC_STORE: begin
        di.op   = op_store;
        di.src1 = rs1;
        di.src2 = rs2;
        di.imm  = imm_s;
      end
      OPC_BRANCH: begin
        di.op   = op_branch;
        di.src1 = rs1;
        di.src2 = rs2;
        di.imm  = imm_b;
      end
      OPC_JAL: begin
        di.op     = op_jal;
        di.imm    = imm_j;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        di.op     = op_jalr;
        di.src1   = rs1;
        di.imm    = imm_i;
        writes_rd = 1'b1;
      end
      OPC_LUI: begin
        di.op     = op_lui;
        di.imm    = imm_u;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        di.op     = op_auipc;
        di.imm    = imm_u;
        writes_rd = 1'b1;
      end
      default: di.illegal = 1'b1;  // system, csr and anything unknown
    endcase

    // x0 writes are discarded, so they never claim a destination
    if (writes_rd) begin
      di.dest_reg       = rd;
      di.dest_reg_valid = (rd != 5'd0);
    end
  end

endmodule

// File: rtl/pip_types_pkg.sv
package pip_types_pkg;

  // ******************************
  // machine width
  // ******************************

  localparam int LANES = 4;

  // ******************************
  // decoded instruction
  // ******************************

  typedef enum logic [3:0] {
    op_alu,
    op_alu_imm,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr,
    op_lui,
    op_auipc,
    op_illegal
  } op_class_t;

  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [31:0] imm;
    logic        illegal;
  } dec_inst_t;

  // ******************************
  // queue payloads
  // ******************************

  typedef struct packed {
    logic [LANES-1:0][31:0] inst_word;
    logic [LANES-1:0][31:0] pc;
    logic [LANES-1:0]       lane_valid;
    logic                   stream;
  } fetch_bundle_t;

  typedef struct packed {
    dec_inst_t  dec_inst;
    logic [7:0] rob_slot;  // upper bits stay zero for shallower reorder buffers
    logic       stream;
  } iq_entry_t;

  typedef struct packed {
    iq_entry_t [LANES-1:0] entries;  // valid entries are packed into the low lanes
    logic [1:0]            count_m1;
  } dispatch_group_t;

endpackage

// File: rtl/rob_alloc.sv
`timescale 1ns/100ps

module rob_alloc import pip_types_pkg::*; #(
  parameter int ROB_DEPTHLOG2 = 4
) (
  input  logic                                 clock,
  input  logic                                 reset_n,
  input  logic                                 reserve,
  input  logic [1:0]                           reserve_count,
  input  logic                                 retire_valid,
  input  logic [1:0]                           retire_count,
  output logic [LANES-1:0][ROB_DEPTHLOG2-1:0] reserved_slots,
  output logic                                 rob_full
);

  localparam int ROB_DEPTH = 1 << ROB_DEPTHLOG2;
  localparam int CW        = ROB_DEPTHLOG2 + 1;

  logic [ROB_DEPTHLOG2-1:0] tail;
  logic [CW-1:0]            free_cnt;
  logic [CW-1:0]            take;
  logic [CW-1:0]            give;

  // ******************************
  // slot offer to decode
  // ******************************

  // lane k is offered tail+k, the adder wraps at the depth by truncation
  always_comb begin
    for (int k = 0; k < LANES; k++)
      reserved_slots[k] = tail + ROB_DEPTHLOG2'(k);
  end

  // a full group may need every lane, so less than LANES free means full
  assign rob_full = (free_cnt < CW'(LANES));

  // ******************************
  // tail and free count
  // ******************************

  assign take = reserve      ? CW'(reserve_count) + 1'b1 : '0;
  assign give = retire_valid ? CW'(retire_count) + 1'b1  : '0;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      tail     <= '0;
      free_cnt <= CW'(ROB_DEPTH);
    end else begin
      if (reserve)
        tail <= tail + ROB_DEPTHLOG2'(reserve_count) + 1'b1;
      free_cnt <= free_cnt - take + give;  // retirement frees the oldest slots
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb \
  -f verilog.f -o dispatch_sim \
  && ./obj_dir/dispatch_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tests/dispatch_tb.sv
`timescale 1ns/100ps

module dispatch_tb import pip_types_pkg::*; ();

  localparam int ROB_DEPTHLOG2 = 4;
  localparam int ROB_DEPTH     = 1 << ROB_DEPTHLOG2;
  localparam int FETCH_DEPTH   = 4;
  localparam int IQ_DEPTH      = 4;

  localparam int RANDOM_BUNDLES = 200;
  localparam int PRE_FLUSH      = 12;
  localparam int FLUSHED        = 8;
  localparam int AFTER_FLUSH    = 30;
  localparam int ROB_FILL       = 24;
  localparam int TOTAL_BUNDLES  = RANDOM_BUNDLES + PRE_FLUSH + FLUSHED + AFTER_FLUSH + ROB_FILL;

  // the last four opcodes have no decode and must come out illegal
  localparam logic [6:0] OPC_TABLE [16] = '{
    7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
    7'b1100111, 7'b0110111, 7'b0010111, 7'b0010011, 7'b0000011, 7'b1100011,
    7'b1110011, 7'b0001111, 7'b0000000, 7'b1111111
  };

  logic            clock;
  logic            reset_n;
  logic            fetch_valid;
  fetch_bundle_t   fetch_bundle;
  logic            fetch_ready;
  logic            flush;
  logic            flush_stream;
  logic            retire_valid;
  logic [1:0]      retire_count;
  logic            group_valid;
  dispatch_group_t group;
  logic            group_ready;

  logic [31:0]     lfsr;
  dispatch_group_t exp_q [$];
  bit              opt_q [$];  // set where the flush may still swallow the group
  fetch_bundle_t   pending;
  bit              have_pending;
  int              push_left;
  logic [31:0]     next_pc;
  logic            cur_stream;
  bit              pre_flush;
  bit              block_s0;
  bit              flush_on;
  bit              force_push;
  bit              ready_always;
  bit              retire_on;
  int              next_slot;
  int              outstanding;
  int              issued;

  tb_clock #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (10)
  ) u_clock (
    .clock   (clock),
    .reset_n (reset_n)
  );

  dispatch_top #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2),
    .FETCH_DEPTH   (FETCH_DEPTH),
    .IQ_DEPTH      (IQ_DEPTH)
  ) i_dut (
    .clock        (clock),
    .reset_n      (reset_n),
    .fetch_valid  (fetch_valid),
    .fetch_bundle (fetch_bundle),
    .fetch_ready  (fetch_ready),
    .flush        (flush),
    .flush_stream (flush_stream),
    .retire_valid (retire_valid),
    .retire_count (retire_count),
    .group_valid  (group_valid),
    .group        (group),
    .group_ready  (group_ready)
  );

  // ******************************
  // random numbers
  // ******************************

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // ******************************
  // reference decode
  // ******************************

  function automatic op_class_t ref_class(input logic [6:0] opc);
    case (opc)
      7'b0110011: return op_alu;
      7'b0010011: return op_alu_imm;
      7'b0000011: return op_load;
      7'b0100011: return op_store;
      7'b1100011: return op_branch;
      7'b1101111: return op_jal;
      7'b1100111: return op_jalr;
      7'b0110111: return op_lui;
      7'b0010111: return op_auipc;
      default:    return op_illegal;
    endcase
  endfunction

  // fields a class does not use stay zero
  function automatic dec_inst_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
    dec_inst_t d;
    d         = '0;
    d.pc      = pc;
    d.op      = ref_class(w[6:0]);
    d.illegal = (d.op == op_illegal);
    if (d.op inside {op_alu, op_alu_imm, op_load, op_jal, op_jalr, op_lui, op_auipc}) begin
      d.dest_reg       = w[11:7];
      d.dest_reg_valid = (w[11:7] != 5'd0);
    end
    if (d.op inside {op_alu, op_alu_imm, op_load, op_store, op_branch, op_jalr})
      d.src1 = w[19:15];
    if (d.op inside {op_alu, op_store, op_branch})
      d.src2 = w[24:20];
    case (d.op)
      op_alu_imm, op_load, op_jalr: d.imm = {{20{w[31]}}, w[31:20]};
      op_store:       d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      op_branch:      d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      op_lui, op_auipc: d.imm = {w[31:12], 12'h000};
      op_jal:         d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:        d.imm = '0;
    endcase
    return d;
  endfunction

  // ******************************
  // failure reporting
  // ******************************

  task automatic fail_value(input string sig, input logic [127:0] exp_v,
                            input logic [127:0] act_v);
    $display("Fail %0t: %s expected %h, got %h", $time, sig, exp_v, act_v);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic fail_text(input string msg);
    $display("%0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // ******************************
  // stimulus and model
  // ******************************

  task automatic make_bundle(output fetch_bundle_t b);
    logic [31:0] upper;
    logic [31:0] idx;
    b = '0;
    for (int k = 0; k < LANES; k++) begin
      upper          = rand_bits(25);
      idx            = rand_bits(4);
      b.inst_word[k] = {upper[24:0], OPC_TABLE[idx[3:0]]};
      b.pc[k]        = next_pc;
      next_pc        = next_pc + 32'd4;
    end
    b.lane_valid = 4'(rand_bits(4));
    b.stream     = cur_stream;
  endtask

  task automatic model_push(input fetch_bundle_t b);
    dispatch_group_t g;
    int              n;
    g = '0;
    n = 0;
    if (b.stream == 1'b0 && block_s0)
      return;  // pushed under the flush, must never come out
    for (int k = 0; k < LANES; k++) begin
      if (b.lane_valid[k]) begin
        g.entries[n].dec_inst = ref_decode(b.pc[k], b.inst_word[k]);
        g.entries[n].stream   = b.stream;
        n++;
      end
    end
    if (n == 0)
      return;
    g.count_m1 = 2'(n - 1);
    exp_q.push_back(g);
    opt_q.push_back(pre_flush);
  endtask

  task automatic check_group(input dispatch_group_t g);
    dispatch_group_t e;
    int              n;
    logic [7:0]      slot;
    // the first stream 1 group proves every pre-flush bundle still waiting was dropped
    if (g.entries[0].stream) begin
      while (opt_q.size() != 0 && opt_q[0]) begin
        void'(exp_q.pop_front());
        void'(opt_q.pop_front());
      end
    end
    assert (exp_q.size() != 0)
      else fail_text("a group was issued that matches no pushed bundle");
    e = exp_q.pop_front();
    void'(opt_q.pop_front());
    assert (g.count_m1 == e.count_m1)
      else fail_value("group.count_m1", 128'(e.count_m1), 128'(g.count_m1));
    n = int'(e.count_m1) + 1;
    for (int k = 0; k < n; k++) begin
      slot = 8'((next_slot + k) % ROB_DEPTH);
      assert (g.entries[k].dec_inst == e.entries[k].dec_inst)
        else fail_value($sformatf("group.entries[%0d].dec_inst", k),
                        128'(e.entries[k].dec_inst), 128'(g.entries[k].dec_inst));
      assert (g.entries[k].stream == e.entries[k].stream)
        else fail_value($sformatf("group.entries[%0d].stream", k),
                        128'(e.entries[k].stream), 128'(g.entries[k].stream));
      assert (g.entries[k].rob_slot == slot)
        else fail_value($sformatf("group.entries[%0d].rob_slot", k),
                        128'(slot), 128'(g.entries[k].rob_slot));
    end
    next_slot   = (next_slot + n) % ROB_DEPTH;
    outstanding = outstanding + n;
    issued++;
    assert (outstanding <= ROB_DEPTH)
      else fail_text("more slots are in use than the reorder buffer holds");
  endtask

  // drive on the falling edge, then sample the handshakes once they have settled
  task automatic run_cycle();
    int n;
    @(negedge clock);
    if (push_left > 0) begin
      if (!have_pending) begin
        make_bundle(pending);
        have_pending = 1'b1;
      end
      fetch_valid  = force_push || (rand_bits(1) != 0);
      fetch_bundle = pending;
    end else begin
      fetch_valid = 1'b0;
    end
    group_ready  = ready_always || (rand_bits(2) != 0);
    flush        = flush_on;
    flush_stream = 1'b0;
    retire_valid = 1'b0;
    if (retire_on && outstanding > 0 && rand_bits(1) != 0) begin
      n = int'(rand_bits(2)) + 1;
      if (n > outstanding)
        n = outstanding;
      retire_valid = 1'b1;
      retire_count = 2'(n - 1);
    end
    #1;
    if (fetch_valid && fetch_ready) begin
      model_push(pending);
      have_pending = 1'b0;
      push_left--;
    end
    if (group_valid && group_ready)
      check_group(group);
    if (retire_valid)
      outstanding = outstanding - (int'(retire_count) + 1);
  endtask

  task automatic drain();
    push_left = 0;
    while (exp_q.size() != 0)
      run_cycle();
    repeat (20) run_cycle();  // a stray group here has nothing left to match
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    int held;
    lfsr         = 32'hfe28;
    fetch_valid  = 1'b0;
    fetch_bundle = '0;
    flush        = 1'b0;
    flush_stream = 1'b0;
    retire_valid = 1'b0;
    retire_count = 2'd0;
    group_ready  = 1'b0;
    have_pending = 1'b0;
    next_pc      = 32'h0000_1000;
    cur_stream   = 1'b0;
    pre_flush    = 1'b0;
    block_s0     = 1'b0;
    flush_on     = 1'b0;
    force_push   = 1'b0;
    ready_always = 1'b1;
    retire_on    = 1'b1;
    next_slot    = 0;
    outstanding  = 0;
    issued       = 0;
    push_left    = 0;

    // both handshakes stay low while reset is held
    @(negedge clock);
    #1;
    assert (fetch_ready == 1'b0)
      else fail_value("fetch_ready", 128'(1'b0), 128'(fetch_ready));
    assert (group_valid == 1'b0)
      else fail_value("group_valid", 128'(1'b0), 128'(group_valid));
    ready_always = 1'b0;
    @(posedge reset_n);

    push_left = RANDOM_BUNDLES;
    while (push_left > 0)
      run_cycle();
    drain();

    // stream 0 runs into a flush, then stream 1 takes over
    pre_flush = 1'b1;
    push_left = PRE_FLUSH;
    while (push_left > 0)
      run_cycle();
    pre_flush = 1'b0;
    block_s0  = 1'b1;
    flush_on  = 1'b1;
    push_left = FLUSHED;
    while (push_left > 0)
      run_cycle();
    flush_on   = 1'b0;
    cur_stream = 1'b1;
    push_left  = AFTER_FLUSH;
    while (push_left > 0)
      run_cycle();
    drain();

    // no retirement, so dispatch has to stop once the reorder buffer fills
    retire_on    = 1'b0;
    ready_always = 1'b1;
    force_push   = 1'b1;
    push_left    = ROB_FILL;
    repeat (40) run_cycle();
    held = issued;
    repeat (20) run_cycle();
    assert (issued == held)
      else fail_text("groups kept issuing while the reorder buffer was full");
    assert (outstanding > ROB_DEPTH - LANES)
      else fail_text("dispatch stopped while four or more slots were still free");
    retire_on    = 1'b1;
    ready_always = 1'b0;
    force_push   = 1'b0;
    while (push_left > 0)
      run_cycle();
    drain();

    if (exp_q.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("%0d expected groups were never issued", exp_q.size());
      $display("Checks failed");
      $fatal(1);
    end
  end

  initial begin
    repeat (TOTAL_BUNDLES * 40) @(posedge clock);
    $display("watchdog expired after %0d cycles with %0d groups still expected",
             TOTAL_BUNDLES * 40, exp_q.size());
    $display("Checks failed");
    $fatal(1);
  end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // reset lifts on a falling edge, away from the edge the design samples on
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
  end

endmodule

// File: verilog.f
rtl/pip_types_pkg.sv
rtl/idec.sv
rtl/entry_fifo.sv
rtl/rob_alloc.sv
rtl/id.sv
rtl/dispatch_top.sv
tests/tb_clock.sv
tests/dispatch_tb.sv
